/* build.f */
+incdir+hdl
hdl/haar_pkg.sv
hdl/haar_ifaces.sv
hdl/db_word_fifo.sv
hdl/integral_window.sv
hdl/feature_evaluator.sv
hdl/haar_stage_ctrl.sv
hdl/haar_stage_top.sv
testbench/haar_stage_asserts.sv
testbench/tb_haar_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_haar_stage -f build.f \
	--Mdir obj_dir -o sim_haar_stage

sim_out=$(./obj_dir/sim_haar_stage)
echo "$sim_out"

if grep -qF "*** TEST PASSED ***" <<< "$sim_out"; then
	exit 0
fi
exit 1

/* testbench/tb_haar_stage.sv */
`timescale 1ns/1ps
`include "haar_params.svh"
`default_nettype none

module tb_haar_stage;

	localparam int DB_LEN    = 9 * `HAAR_FEATURES + 1;
	localparam int TIMEOUT   = 400;
	localparam int ANY       = 0;
	localparam int WANT_HIT  = 1;
	localparam int WANT_MISS = 2;

	logic                    clk_fpga;
	logic                    reset_fpga;
	logic                    db_valid;
	logic [`HAAR_WORD_W-1:0] db_word;
	logic                    db_credit;
	logic                    ii_we;
	logic [3:0]              ii_row;
	logic [3:0]              ii_col;
	logic [`HAAR_II_W-1:0]   ii_data;
	logic                    start;
	logic                    result_valid;
	logic                    candidate;

	int                      pix [`HAAR_WIN][`HAAR_WIN];
	logic [`HAAR_WORD_W-1:0] db_words [DB_LEN];
	bit                      expected, first_expected, last_candidate;
	int                      credits, pending, credits_back, words_sent, results;
	int                      checks, errors, timeouts;

	haar_stage_top u_dut (.*);

	initial
	begin
		clk_fpga = 1'b0;
		forever #4 clk_fpga = ~clk_fpga;
	end

	// Returned credits and result pulses, seen at the edge.
	always @(posedge clk_fpga)
	begin
		if (db_credit)
		begin
			pending++;
			credits_back++;
		end
		if (result_valid)
		begin
			results++;
			last_candidate = candidate;
		end
	end

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($urandom % (hi - lo + 1));
	endfunction

	function automatic int window_sum(input int x, input int y, input int w, input int h);
		int s;
		s = 0;
		for (int r = y; r < y + h; r++)
			for (int c = x; c < x + w; c++)
				s += pix[r][c];
		return s;
	endfunction

	task automatic check_value(input string name, input int got, input int want);
		checks++;
		assert (got == want) else
		begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, want);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus and reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic load_image();
		int ii [`HAAR_WIN+1][`HAAR_WIN+1];
		for (int r = 0; r <= `HAAR_WIN; r++)
			for (int c = 0; c <= `HAAR_WIN; c++)
			begin
				ii[r][c] = 0;
				if (r > 0 && c > 0)
				begin
					pix[r-1][c-1] = rand_range(0, 255);
					ii[r][c] = ii[r-1][c] + ii[r][c-1] - ii[r-1][c-1] + pix[r-1][c-1];
				end
				ii_we   = 1'b1;
				ii_row  = 4'(r);
				ii_col  = 4'(c);
				ii_data = 16'(ii[r][c]);
				@(posedge clk_fpga);
				#1;
			end
		ii_we = 1'b0;
	endtask

	task automatic build_stage(input int mode);
		int x, y, w, h, weight, fsum, leaf_sum;
		logic signed [`HAAR_WORD_W-1:0] thresh, left, right, stage_thresh;
		leaf_sum = 0;
		for (int f = 0; f < `HAAR_FEATURES; f++)
		begin
			fsum = 0;
			for (int k = 0; k < 3; k++)
			begin
				x = rand_range(0, `HAAR_WIN - 1);
				y = rand_range(0, `HAAR_WIN - 1);
				w = rand_range(1, `HAAR_WIN - x); // Stays inside the window.
				h = rand_range(1, `HAAR_WIN - y);
				weight = rand_range(-3, 3);
				fsum += weight * window_sum(x, y, w, h);
				db_words[9*f + 2*k]     = {4'(x), 4'(y), 4'(w), 4'(h)};
				db_words[9*f + 2*k + 1] = 16'(weight);
			end
			thresh = 16'(fsum + rand_range(-200, 200));
			left   = 16'(rand_range(-500, 500));
			right  = 16'(rand_range(-500, 500));
			db_words[9*f + 6] = thresh;
			db_words[9*f + 7] = left;
			db_words[9*f + 8] = right;
			leaf_sum += (fsum < thresh) ? left : right;
		end
		case (mode)
			WANT_HIT:  stage_thresh = 16'(leaf_sum - rand_range(1, 20));
			WANT_MISS: stage_thresh = 16'(leaf_sum + rand_range(0, 20));
			default:   stage_thresh = 16'(rand_range(-1000, 1000));
		endcase
		db_words[DB_LEN-1] = stage_thresh;
		expected = (leaf_sum > stage_thresh);
	endtask

	task automatic send_stage(input bit gaps);
		int i, stalled;
		i = 0;
		stalled = 0;
		while (i < DB_LEN && stalled < TIMEOUT)
		begin
			if (!gaps || $urandom % 2 == 0)
			begin
				credits += pending; // With gaps, credits are taken up late.
				pending = 0;
			end
			if (credits > 0 && !(gaps && $urandom % 3 == 0))
			begin
				db_valid = 1'b1;
				db_word  = db_words[i];
				credits--;
				words_sent++;
				i++;
				stalled = 0;
			end
			else
			begin
				db_valid = 1'b0;
				stalled++;
			end
			@(posedge clk_fpga);
			#1;
		end
		db_valid = 1'b0;
		if (i < DB_LEN)
		begin
			timeouts++;
			$display("Timeout: the host waited too long for a credit");
		end
	endtask

	task automatic pulse_start();
		start = 1'b1;
		@(posedge clk_fpga);
		#1;
		start = 1'b0;
	endtask

	task automatic run_stage(input bit gaps, input bit early, input bit extra_start);
		int res0, back0, sent0, n;
		res0  = results;
		back0 = credits_back;
		sent0 = words_sent;
		fork
			send_stage(gaps);
			begin
				if (early)
				begin
					repeat (30) @(posedge clk_fpga);
					#1;
					check_value("words_sent", words_sent - sent0, `HAAR_CREDITS);
					check_value("db_credit", credits_back - back0, 0);
				end
				pulse_start();
				if (extra_start)
				begin
					repeat (10) @(posedge clk_fpga);
					#1;
					pulse_start(); // Busy, so this one is dropped.
				end
			end
		join
		n = 0;
		while (results == res0 && n < TIMEOUT)
		begin
			@(posedge clk_fpga);
			#1;
			n++;
		end
		if (results == res0)
		begin
			timeouts++;
			$display("Timeout: the stage gave no result");
		end
		check_value("candidate", last_candidate, expected);
		repeat (10) @(posedge clk_fpga);
		#1;
		check_value("result_valid", results - res0, 1);
		check_value("db_credit", credits_back - back0, words_sent - sent0);
		check_value("credits", credits + pending, `HAAR_CREDITS);
	endtask

	initial
	begin
		void'($urandom(53));
		reset_fpga = 1'b1;
		db_valid   = 1'b0;
		db_word    = '0;
		ii_we      = 1'b0;
		ii_row     = '0;
		ii_col     = '0;
		ii_data    = '0;
		start      = 1'b0;
		credits    = `HAAR_CREDITS;
		repeat (10) @(posedge clk_fpga);
		#1;
		reset_fpga = 1'b0;
		check_value("result_valid", result_valid, 0);
		check_value("candidate", candidate, 0);
		load_image();
		check_value("db_credit", credits_back, 0);

		build_stage(ANY); // Words queued before start.
		first_expected = expected;
		run_stage(1'b0, 1'b1, 1'b0);
		build_stage(ANY);
		run_stage(1'b0, 1'b0, 1'b0);
		build_stage(ANY);
		run_stage(1'b1, 1'b0, 1'b0);

		// New image and the opposite decision.
		load_image();
		build_stage(first_expected ? WANT_MISS : WANT_HIT);
		run_stage(1'b0, 1'b0, 1'b1);

		$display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/haar_stage_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module haar_stage_asserts
(
	input logic clk_fpga,
	input logic reset_fpga,
	input logic db_valid,
	input logic fifo_full,
	input logic req,
	input logic sum_valid,
	input logic db_credit,
	input logic result_valid,
	input logic candidate
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Protocol rules
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	no_word_when_full: assert property (@(posedge clk_fpga) disable iff (reset_fpga)
		db_valid |-> !fifo_full)
		else $error("Database word arrived while the FIFO was full.");

	sum_after_req: assert property (@(posedge clk_fpga) disable iff (reset_fpga)
		sum_valid == $past(req))
		else $error("Rectangle sum did not follow its request by one cycle.");

	single_result: assert property (@(posedge clk_fpga) disable iff (reset_fpga)
		result_valid |=> !result_valid)
		else $error("result_valid stayed high for more than one cycle.");

	quiet_in_reset: assert property (@(posedge clk_fpga)
		reset_fpga |=> !db_credit && !result_valid && !candidate && !req)
		else $error("An output was high during reset.");

endmodule

bind haar_stage_top haar_stage_asserts u_asserts
(
	.clk_fpga     (clk_fpga),
	.reset_fpga   (reset_fpga),
	.db_valid     (db_valid),
	.fifo_full    (u_fifo.full),
	.req          (lookup_bus.req),
	.sum_valid    (lookup_bus.sum_valid),
	.db_credit    (db_credit),
	.result_valid (result_valid),
	.candidate    (candidate)
);

`default_nettype wire

/* hdl/haar_stage_top.sv */
`timescale 1ns/1ps
`include "haar_params.svh"
`default_nettype none

module haar_stage_top
(
	input  logic                    clk_fpga,
	input  logic                    reset_fpga,
	input  logic                    db_valid,
	input  logic [`HAAR_WORD_W-1:0] db_word,
	output logic                    db_credit,
	input  logic                    ii_we,
	input  logic [3:0]              ii_row,
	input  logic [3:0]              ii_col,
	input  logic [`HAAR_II_W-1:0]   ii_data,
	input  logic                    start,
	output logic                    result_valid,
	output logic                    candidate
);

	db_pop_if      pop_bus ();
	rect_lookup_if lookup_bus ();
	feature_if     feat_bus ();

	db_word_fifo u_fifo (
		.clk_fpga   (clk_fpga),
		.reset_fpga (reset_fpga),
		.db_valid   (db_valid),
		.db_word    (db_word),
		.db_credit  (db_credit),
		.pop_side   (pop_bus.source)
	);

	integral_window u_window (
		.clk_fpga   (clk_fpga),
		.reset_fpga (reset_fpga),
		.ii_we      (ii_we),
		.ii_row     (ii_row),
		.ii_col     (ii_col),
		.ii_data    (ii_data),
		.lookup     (lookup_bus.responder)
	);

	feature_evaluator u_eval (
		.clk_fpga   (clk_fpga),
		.reset_fpga (reset_fpga),
		.sums       (lookup_bus.monitor),
		.feat       (feat_bus.evaluator)
	);

	haar_stage_ctrl u_ctrl (
		.clk_fpga     (clk_fpga),
		.reset_fpga   (reset_fpga),
		.start        (start),
		.result_valid (result_valid),
		.candidate    (candidate),
		.words        (pop_bus.sink),
		.lookup       (lookup_bus.requester),
		.feat         (feat_bus.control)
	);

endmodule

`default_nettype wire

/* hdl/haar_stage_ctrl.sv */
`timescale 1ns/1ps
`include "haar_params.svh"
`default_nettype none

module haar_stage_ctrl
(
	input  logic             clk_fpga,
	input  logic             reset_fpga,
	input  logic             start,
	output logic             result_valid,
	output logic             candidate,
	db_pop_if.sink           words,
	rect_lookup_if.requester lookup,
	feature_if.control       feat
);

	localparam int FEAT_W = $clog2(`HAAR_FEATURES + 1);
	localparam int SUM_W  = `HAAR_WORD_W + $clog2(`HAAR_FEATURES) + 1;

	haar_pkg::db_word_u             cur;
	haar_pkg::word_slot_e           slot;
	logic [FEAT_W-1:0]              feat_cnt;
	logic                           busy;
	logic                           finishing;
	logic                           have_sum;
	logic                           stage_word;
	logic                           is_rect;
	logic                           is_weight;
	logic                           pop_ok;
	logic                           idle;
	logic signed [SUM_W-1:0]        stage_sum;
	logic signed [`HAAR_WORD_W-1:0] stage_thresh;

	assign cur        = words.word;
	assign stage_word = (feat_cnt == FEAT_W'(`HAAR_FEATURES)); // All records done.
	assign is_rect    = !stage_word && (slot inside {haar_pkg::RECT0, haar_pkg::RECT1,
		haar_pkg::RECT2});
	assign is_weight  = slot inside {haar_pkg::WEIGHT0, haar_pkg::WEIGHT1,
		haar_pkg::WEIGHT2};
	assign idle       = !busy && !finishing;

	// Weights hold until the rectangle sum is back.
	assign pop_ok = busy && words.valid && (!is_weight || have_sum || lookup.sum_valid);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Word decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign words.pop          = pop_ok;
	assign lookup.req         = pop_ok && is_rect;
	assign lookup.rect        = cur.rect;
	assign feat.scalar        = cur.scalar;
	assign feat.clear         = lookup.req && (slot == haar_pkg::RECT0);
	assign feat.weight_strobe = pop_ok && is_weight;
	assign feat.thresh_strobe = pop_ok && (slot == haar_pkg::FEAT_THRESH);
	assign feat.left_strobe   = pop_ok && (slot == haar_pkg::LEFT_LEAF);
	assign feat.right_strobe  = pop_ok && (slot == haar_pkg::RIGHT_LEAF);

	always_ff @(posedge clk_fpga)
	begin
		if (pop_ok && stage_word)
			stage_thresh <= cur.scalar;
	end

	always_ff @(posedge clk_fpga)
	begin
		if (reset_fpga)
		begin
			busy         <= 1'b0;
			finishing    <= 1'b0;
			have_sum     <= 1'b0;
			slot         <= haar_pkg::RECT0;
			feat_cnt     <= '0;
			stage_sum    <= '0;
			result_valid <= 1'b0;
			candidate    <= 1'b0;
		end
		else
		begin
			finishing    <= pop_ok && stage_word;
			result_valid <= finishing;
			if (finishing)
				candidate <= (stage_sum > stage_thresh); // Last leaf is in by now.

			if (lookup.req)
				have_sum <= 1'b0;
			else if (lookup.sum_valid)
				have_sum <= 1'b1;

			if (start && idle)
			begin
				busy      <= 1'b1;
				slot      <= haar_pkg::RECT0;
				feat_cnt  <= '0;
				stage_sum <= '0;
			end
			else if (feat.leaf_valid)
				stage_sum <= stage_sum + feat.leaf;

			if (pop_ok)
			begin
				if (stage_word)
					busy <= 1'b0;
				else if (slot == haar_pkg::RIGHT_LEAF)
				begin
					slot     <= haar_pkg::RECT0;
					feat_cnt <= feat_cnt + 1'b1;
				end
				else
					slot <= haar_pkg::word_slot_e'(slot + 1'b1);
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/feature_evaluator.sv */
`timescale 1ns/1ps
`include "haar_params.svh"
`default_nettype none

module feature_evaluator
(
	input  logic           clk_fpga,
	input  logic           reset_fpga,
	rect_lookup_if.monitor sums,
	feature_if.evaluator   feat
);

	localparam int ACC_W  = 34;
	localparam int PROD_W = `HAAR_WORD_W + `HAAR_II_W + 1;

	logic        [`HAAR_II_W-1:0]   rect_sum;
	logic        [`HAAR_II_W-1:0]   cur_sum;
	logic signed [PROD_W-1:0]       product;
	logic signed [ACC_W-1:0]        acc;
	logic signed [`HAAR_WORD_W-1:0] left_leaf;
	logic                           below;

	// A weight may come in the same cycle as its sum.
	assign cur_sum = sums.sum_valid ? sums.sum : rect_sum;
	assign product = $signed(feat.scalar) * $signed({1'b0, cur_sum});

	always_ff @(posedge clk_fpga)
	begin
		if (sums.sum_valid)
			rect_sum <= sums.sum;
		if (feat.thresh_strobe)
			below <= (acc < $signed(feat.scalar)); // Left branch when below.
		if (feat.left_strobe)
			left_leaf <= feat.scalar;
		if (feat.right_strobe)
			feat.leaf <= below ? left_leaf : feat.scalar;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Weighted accumulation
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_fpga)
	begin
		if (reset_fpga)
		begin
			acc             <= '0;
			feat.leaf_valid <= 1'b0;
		end
		else
		begin
			feat.leaf_valid <= feat.right_strobe;
			if (feat.clear)
				acc <= '0; // New feature.
			else if (feat.weight_strobe)
				acc <= acc + product;
		end
	end

endmodule

`default_nettype wire

/* hdl/integral_window.sv */
`timescale 1ns/1ps
`include "haar_params.svh"
`default_nettype none

module integral_window
(
	input  logic                  clk_fpga,
	input  logic                  reset_fpga,
	input  logic                  ii_we,
	input  logic [3:0]            ii_row,
	input  logic [3:0]            ii_col,
	input  logic [`HAAR_II_W-1:0] ii_data,
	rect_lookup_if.responder      lookup
);

	// Row 0 and column 0 hold zeros written by the host.
	logic [`HAAR_II_W-1:0] ii [0:`HAAR_WIN][0:`HAAR_WIN];

	logic [3:0]            x_left;
	logic [3:0]            x_right;
	logic [3:0]            y_top;
	logic [3:0]            y_bottom;
	logic [`HAAR_II_W-1:0] top_left;
	logic [`HAAR_II_W-1:0] top_right;
	logic [`HAAR_II_W-1:0] bottom_left;
	logic [`HAAR_II_W-1:0] bottom_right;

	assign x_left   = lookup.rect.x;
	assign x_right  = lookup.rect.x + lookup.rect.w;
	assign y_top    = lookup.rect.y;
	assign y_bottom = lookup.rect.y + lookup.rect.h;

	assign top_left     = ii[y_top][x_left];
	assign top_right    = ii[y_top][x_right];
	assign bottom_left  = ii[y_bottom][x_left];
	assign bottom_right = ii[y_bottom][x_right];

	always_ff @(posedge clk_fpga)
	begin
		if (ii_we)
			ii[ii_row][ii_col] <= ii_data;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Four-corner sum, one cycle after the request
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_fpga)
	begin
		if (lookup.req)
			lookup.sum <= bottom_right - top_right - bottom_left + top_left;
	end

	always_ff @(posedge clk_fpga)
	begin
		if (reset_fpga)
			lookup.sum_valid <= 1'b0;
		else
			lookup.sum_valid <= lookup.req;
	end

endmodule

`default_nettype wire

/* hdl/db_word_fifo.sv */
`timescale 1ns/1ps
`include "haar_params.svh"
`default_nettype none

module db_word_fifo
(
	input  logic                    clk_fpga,
	input  logic                    reset_fpga,
	input  logic                    db_valid,
	input  logic [`HAAR_WORD_W-1:0] db_word,
	output logic                    db_credit,
	db_pop_if.source                pop_side
);

	localparam int PTR_W = $clog2(`HAAR_CREDITS);
	localparam int CNT_W = $clog2(`HAAR_CREDITS + 1);

	logic [`HAAR_WORD_W-1:0] buffer [`HAAR_CREDITS];
	logic [PTR_W-1:0]        wr_ptr;
	logic [PTR_W-1:0]        rd_ptr;
	logic [CNT_W-1:0]        count;
	logic                    full;
	logic                    do_write;
	logic                    do_pop;

	assign full     = (count == CNT_W'(`HAAR_CREDITS));
	assign do_write = db_valid && !full; // Host credits keep this true.
	assign do_pop   = pop_side.pop && pop_side.valid;

	assign pop_side.valid = (count != '0);
	assign pop_side.word  = buffer[rd_ptr]; // Head word, no register.

	always_ff @(posedge clk_fpga)
	begin
		if (do_write)
			buffer[wr_ptr] <= db_word;
	end

	always_ff @(posedge clk_fpga)
	begin
		if (reset_fpga)
		begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			db_credit <= 1'b0;
		end
		else
		begin
			db_credit <= do_pop; // Slot freed, give the credit back.
			if (do_write)
				wr_ptr <= (wr_ptr == PTR_W'(`HAAR_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(`HAAR_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_write, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/haar_ifaces.sv */
`timescale 1ns/1ps
`include "haar_params.svh"
`default_nettype none

// Head of the database FIFO.
interface db_pop_if;
	logic                   valid;
	logic [`HAAR_WORD_W-1:0] word;
	logic                   pop;

	modport source (output valid, output word, input pop);
	modport sink (input valid, input word, output pop);
endinterface

// Rectangle sum request and its answer one cycle later.
interface rect_lookup_if;
	logic                  req;
	haar_pkg::rect_t       rect;
	logic [`HAAR_II_W-1:0] sum;
	logic                  sum_valid;

	modport requester (output req, output rect, input sum, input sum_valid);
	modport responder (input req, input rect, output sum, output sum_valid);
	modport monitor (input sum, input sum_valid);
endinterface

// Strobes into the feature evaluator.
interface feature_if;
	logic                           clear;
	logic                           weight_strobe;
	logic                           thresh_strobe;
	logic                           left_strobe;
	logic                           right_strobe;
	logic signed [`HAAR_WORD_W-1:0] scalar;
	logic                           leaf_valid;
	logic signed [`HAAR_WORD_W-1:0] leaf;

	modport control (output clear, weight_strobe, thresh_strobe, left_strobe,
		right_strobe, scalar, input leaf_valid, leaf);
	modport evaluator (input clear, weight_strobe, thresh_strobe, left_strobe,
		right_strobe, scalar, output leaf_valid, leaf);
endinterface

`default_nettype wire

/* hdl/haar_pkg.sv */
`include "haar_params.svh"
`default_nettype none

package haar_pkg;

	// Rectangle inside the window, corner at (y,x).
	typedef struct packed {
		logic [3:0] x;
		logic [3:0] y;
		logic [3:0] w;
		logic [3:0] h;
	} rect_t;

	// One database word, seen either as a rectangle or as a number.
	typedef union packed {
		rect_t                          rect;
		logic signed [`HAAR_WORD_W-1:0] scalar;
	} db_word_u;

	// Word order inside one feature record.
	typedef enum logic [3:0] {
		RECT0,
		WEIGHT0,
		RECT1,
		WEIGHT1,
		RECT2,
		WEIGHT2,
		FEAT_THRESH,
		LEFT_LEAF,
		RIGHT_LEAF
	} word_slot_e;

endpackage

`default_nettype wire

/* hdl/haar_params.svh */
`ifndef HAAR_PARAMS_SVH
`define HAAR_PARAMS_SVH

`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Window and word sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define HAAR_WIN      8    // Side of the detection window in pixels.
`define HAAR_WORD_W   16   // Database word.
`define HAAR_II_W     16   // Holds 64 pixels of 255.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stage shape and flow control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define HAAR_FEATURES 4    // Features per stage.
`define HAAR_CREDITS  4    // FIFO depth and initial host credits.

`default_nettype wire

`endif
